//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_axi2per
RTL_TOP   ?= axi2per_top
BUILD_DIR ?= build
VFLAGS    ?= --timing

SOURCES := $(wildcard src/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- src.f
+incdir+testbench
src/axi2per_pkg.sv
src/per_bus_if.sv
src/axi2per_req_channel.sv
src/per_reg_bank.sv
src/axi2per_res_channel.sv
src/axi2per_top.sv
testbench/tb_axi2per.sv

//--- src/axi2per_pkg.sv
package axi2per_pkg;

   // ******************************
   // Bus widths
   // ******************************
   localparam int unsigned AXI_ADDR_WIDTH = 32;
   localparam int unsigned AXI_DATA_WIDTH = 64;
   localparam int unsigned AXI_ID_WIDTH   = 4;
   localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
   localparam int unsigned PER_DATA_WIDTH = 32;
   localparam int unsigned PER_BE_WIDTH   = PER_DATA_WIDTH / 8;

   // ******************************
   // Bank geometry
   // ******************************
   localparam int unsigned BANK_SEL_LSB   = 8;
   localparam int unsigned BANK_SEL_WIDTH = 2;                // Address bits 9:8
   localparam int unsigned WORD_IDX_WIDTH = BANK_SEL_LSB - 2; // Word index inside a bank

   // AXI response codes
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // Peripheral operation, echoed back with the response
   typedef enum logic {
      PER_WRITE = 1'b0,
      PER_READ  = 1'b1
   } per_opc_e;

   // Handed from request to response channel with each transfer
   typedef struct packed {
      logic                      write;
      logic [AXI_ID_WIDTH-1:0]   id;
      logic                      half;  // Address bit 2
      logic [BANK_SEL_WIDTH-1:0] bank;
   } trans_info_t;

endpackage

//--- src/axi2per_req_channel.sv
`timescale 1ns/1ps

module axi2per_req_channel #(
   parameter int unsigned N_BANKS = 4
) (
   input  logic                                   clk_i,
   input  logic                                   rst_ni,
   // Read address
   input  logic                                   ar_valid_i,
   input  logic [axi2per_pkg::AXI_ADDR_WIDTH-1:0] ar_addr_i,
   input  logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   ar_id_i,
   output logic                                   ar_ready_o,
   // Write address and data
   input  logic                                   aw_valid_i,
   input  logic [axi2per_pkg::AXI_ADDR_WIDTH-1:0] aw_addr_i,
   input  logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   aw_id_i,
   output logic                                   aw_ready_o,
   input  logic                                   w_valid_i,
   input  logic [axi2per_pkg::AXI_DATA_WIDTH-1:0] w_data_i,
   input  logic [axi2per_pkg::AXI_STRB_WIDTH-1:0] w_strb_i,
   output logic                                   w_ready_o,
   // Handoff to the response channel
   output logic                                   trans_req_o,
   output axi2per_pkg::trans_info_t               trans_info_o,
   input  logic                                   trans_done_i,
   per_bus_if.master                              per_o [N_BANKS-1:0]
);
   import axi2per_pkg::*;

   typedef enum logic [1:0] {IDLE, ISSUE, WAIT_RESP} state_e;

   state_e                    state_q, state_d;
   logic                      we_q;
   logic [AXI_ID_WIDTH-1:0]   id_q;
   logic                      half_q;
   logic [BANK_SEL_WIDTH-1:0] bank_q;
   logic [WORD_IDX_WIDTH-1:0] add_q;
   logic [PER_DATA_WIDTH-1:0] wdata_q;
   logic [PER_BE_WIDTH-1:0]   be_q;
   logic [N_BANKS-1:0]        bank_gnt;
   logic                      gnt_sel;

   // ******************************
   // Control FSM
   // ******************************
   always_comb
   begin
      state_d    = state_q;
      ar_ready_o = 1'b0;
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      case (state_q)
         IDLE:
         begin
            if (ar_valid_i) // Reads win
            begin
               ar_ready_o = 1'b1;
               state_d    = ISSUE;
            end
            else if (aw_valid_i && w_valid_i)
            begin
               aw_ready_o = 1'b1;
               w_ready_o  = 1'b1;
               state_d    = ISSUE;
            end
         end
         ISSUE:
         begin
            if (gnt_sel)
               state_d = WAIT_RESP;
         end
         WAIT_RESP:
         begin
            if (trans_done_i)
               state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // Transfer fields, loaded on the address handshake
   always_ff @(posedge clk_i)
   begin
      if (ar_ready_o)
      begin
         we_q   <= 1'b0;
         id_q   <= ar_id_i;
         half_q <= ar_addr_i[2];
         bank_q <= ar_addr_i[BANK_SEL_LSB +: BANK_SEL_WIDTH];
         add_q  <= ar_addr_i[BANK_SEL_LSB-1:2];
      end
      else if (aw_ready_o)
      begin
         we_q    <= 1'b1;
         id_q    <= aw_id_i;
         half_q  <= aw_addr_i[2];
         bank_q  <= aw_addr_i[BANK_SEL_LSB +: BANK_SEL_WIDTH];
         add_q   <= aw_addr_i[BANK_SEL_LSB-1:2];
         wdata_q <= aw_addr_i[2] ? w_data_i[AXI_DATA_WIDTH-1:PER_DATA_WIDTH]
                                 : w_data_i[PER_DATA_WIDTH-1:0];
         be_q    <= aw_addr_i[2] ? w_strb_i[AXI_STRB_WIDTH-1:PER_BE_WIDTH]
                                 : w_strb_i[PER_BE_WIDTH-1:0];
      end
   end

   // ******************************
   // Peripheral links
   // ******************************
   for (genvar g = 0; g < N_BANKS; g++)
   begin : gen_link
      assign per_o[g].req   = (state_q == ISSUE) && (bank_q == BANK_SEL_WIDTH'(g));
      assign per_o[g].add   = add_q;
      assign per_o[g].we    = we_q;
      assign per_o[g].wdata = wdata_q;
      assign per_o[g].be    = be_q;
      assign bank_gnt[g]    = per_o[g].gnt;
   end

   assign gnt_sel = bank_gnt[bank_q];

   assign trans_req_o  = (state_q == ISSUE) && gnt_sel; // Same cycle as the accepted request
   assign trans_info_o = '{write: we_q, id: id_q, half: half_q, bank: bank_q};

endmodule

//--- src/axi2per_res_channel.sv
`timescale 1ns/1ps

module axi2per_res_channel #(
   parameter int unsigned N_BANKS = 4
) (
   input  logic                                   clk_i,
   input  logic                                   rst_ni,
   per_bus_if.master                              per_i [N_BANKS-1:0],
   // Handoff from the request channel
   input  logic                                   trans_req_i,
   input  axi2per_pkg::trans_info_t               trans_info_i,
   output logic                                   trans_done_o,
   // Read data
   output logic                                   r_valid_o,
   output logic [axi2per_pkg::AXI_DATA_WIDTH-1:0] r_data_o,
   output axi2per_pkg::axi_resp_e                 r_resp_o,
   output logic                                   r_last_o,
   output logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   r_id_o,
   input  logic                                   r_ready_i,
   // Write response
   output logic                                   b_valid_o,
   output axi2per_pkg::axi_resp_e                 b_resp_o,
   output logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   b_id_o,
   input  logic                                   b_ready_i
);
   import axi2per_pkg::*;

   typedef enum logic {TRANS_IDLE, TRANS_PENDING} state_e;

   state_e                    state_q, state_d;
   trans_info_t               info_q;
   logic [PER_DATA_WIDTH-1:0] rdata_q;
   logic [N_BANKS-1:0]        bank_rvalid;
   logic [PER_DATA_WIDTH-1:0] bank_rdata [N_BANKS];
   per_opc_e                  bank_opc [N_BANKS];
   logic                      rsp_valid;

   // ******************************
   // Bank response select
   // ******************************
   for (genvar g = 0; g < N_BANKS; g++)
   begin : gen_rsp
      assign bank_rvalid[g] = per_i[g].r_valid;
      assign bank_rdata[g]  = per_i[g].r_rdata;
      assign bank_opc[g]    = per_i[g].r_opc;
   end

   assign rsp_valid = bank_rvalid[info_q.bank];

   // Transfer info for the one transaction in flight
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         info_q <= '0;
      else if (trans_req_i)
         info_q <= trans_info_i;
   end

   // Read word, only taken from read responses
   always_ff @(posedge clk_i)
   begin
      if (state_q == TRANS_IDLE && rsp_valid && bank_opc[info_q.bank] == PER_READ)
         rdata_q <= bank_rdata[info_q.bank];
   end

   // ******************************
   // Response FSM
   // ******************************
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         TRANS_IDLE:
         begin
            if (rsp_valid)
               state_d = TRANS_PENDING;
         end
         TRANS_PENDING:
         begin
            if (trans_done_o)
               state_d = TRANS_IDLE;
         end
         default: state_d = TRANS_IDLE;
      endcase
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= TRANS_IDLE;
      else
         state_q <= state_d;
   end

   // Held until the handshake
   assign r_valid_o    = (state_q == TRANS_PENDING) && !info_q.write;
   assign b_valid_o    = (state_q == TRANS_PENDING) && info_q.write;
   assign trans_done_o = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);

   assign r_data_o = info_q.half ? {rdata_q, {PER_DATA_WIDTH{1'b0}}}
                                 : {{PER_DATA_WIDTH{1'b0}}, rdata_q};
   assign r_resp_o = OKAY;
   assign r_last_o = 1'b1; // Single beat only
   assign r_id_o   = info_q.id;
   assign b_resp_o = OKAY;
   assign b_id_o   = info_q.id;

endmodule

//--- src/axi2per_top.sv
`timescale 1ns/1ps

module axi2per_top #(
   parameter int unsigned N_BANKS    = 4,
   parameter int unsigned BANK_WORDS = 64
) (
   input  logic                                   clk_i,
   input  logic                                   rst_ni,
   // Read address
   input  logic                                   ar_valid_i,
   input  logic [axi2per_pkg::AXI_ADDR_WIDTH-1:0] ar_addr_i,
   input  logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   ar_id_i,
   output logic                                   ar_ready_o,
   // Write address
   input  logic                                   aw_valid_i,
   input  logic [axi2per_pkg::AXI_ADDR_WIDTH-1:0] aw_addr_i,
   input  logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   aw_id_i,
   output logic                                   aw_ready_o,
   // Write data
   input  logic                                   w_valid_i,
   input  logic [axi2per_pkg::AXI_DATA_WIDTH-1:0] w_data_i,
   input  logic [axi2per_pkg::AXI_STRB_WIDTH-1:0] w_strb_i,
   output logic                                   w_ready_o,
   // Read data
   output logic                                   r_valid_o,
   output logic [axi2per_pkg::AXI_DATA_WIDTH-1:0] r_data_o,
   output axi2per_pkg::axi_resp_e                 r_resp_o,
   output logic                                   r_last_o,
   output logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   r_id_o,
   input  logic                                   r_ready_i,
   // Write response
   output logic                                   b_valid_o,
   output axi2per_pkg::axi_resp_e                 b_resp_o,
   output logic [axi2per_pkg::AXI_ID_WIDTH-1:0]   b_id_o,
   input  logic                                   b_ready_i
);
   import axi2per_pkg::*;

   logic        trans_req;
   trans_info_t trans_info;
   logic        trans_done;

   per_bus_if per_bus [N_BANKS-1:0] ();  // One link per bank

   axi2per_req_channel #(
      .N_BANKS (N_BANKS)
   ) req_channel_i (
      .clk_i, .rst_ni,
      .ar_valid_i, .ar_addr_i, .ar_id_i, .ar_ready_o,
      .aw_valid_i, .aw_addr_i, .aw_id_i, .aw_ready_o,
      .w_valid_i, .w_data_i, .w_strb_i, .w_ready_o,
      .trans_req_o  (trans_req),
      .trans_info_o (trans_info),
      .trans_done_i (trans_done),
      .per_o        (per_bus)
   );

   // ******************************
   // Register banks
   // ******************************
   for (genvar g = 0; g < N_BANKS; g++)
   begin : gen_bank
      per_reg_bank #(
         .BANK_WORDS (BANK_WORDS)
      ) bank_i (
         .clk_i, .rst_ni,
         .per_i (per_bus[g])
      );
   end

   axi2per_res_channel #(
      .N_BANKS (N_BANKS)
   ) res_channel_i (
      .clk_i, .rst_ni,
      .per_i        (per_bus),
      .trans_req_i  (trans_req),
      .trans_info_i (trans_info),
      .trans_done_o (trans_done),
      .r_valid_o, .r_data_o, .r_resp_o, .r_last_o, .r_id_o, .r_ready_i,
      .b_valid_o, .b_resp_o, .b_id_o, .b_ready_i
   );

endmodule

//--- src/per_bus_if.sv
`timescale 1ns/1ps

interface per_bus_if;
   import axi2per_pkg::*;

   // Request
   logic                      req;
   logic [WORD_IDX_WIDTH-1:0] add;   // Word index
   logic                      we;    // 1 for write
   logic [PER_DATA_WIDTH-1:0] wdata;
   logic [PER_BE_WIDTH-1:0]   be;
   logic                      gnt;

   // Response
   logic                      r_valid;
   logic [PER_DATA_WIDTH-1:0] r_rdata;
   per_opc_e                  r_opc;

   modport master (
      output req, add, we, wdata, be,
      input  gnt,
      input  r_valid, r_rdata, r_opc
   );

   modport slave (
      input  req, add, we, wdata, be,
      output gnt,
      output r_valid, r_rdata, r_opc
   );

endinterface

//--- src/per_reg_bank.sv
`timescale 1ns/1ps

module per_reg_bank #(
   parameter int unsigned BANK_WORDS = 64
) (
   input  logic      clk_i,
   input  logic      rst_ni,
   per_bus_if.slave  per_i
);
   import axi2per_pkg::*;

   logic [PER_DATA_WIDTH-1:0] mem_q [BANK_WORDS];
   logic                      r_valid_q;
   per_opc_e                  r_opc_q;
   logic [PER_DATA_WIDTH-1:0] r_rdata_q;
   logic                      req_ok;

   assign per_i.gnt = 1'b1;               // Always ready
   assign req_ok    = per_i.req && per_i.gnt;

   // Storage, cleared on reset
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         for (int i = 0; i < BANK_WORDS; i++)
            mem_q[i] <= '0;
      end
      else if (req_ok && per_i.we)
      begin
         for (int b = 0; b < PER_BE_WIDTH; b++)
            if (per_i.be[b])
               mem_q[per_i.add][8*b +: 8] <= per_i.wdata[8*b +: 8];
      end
   end

   // Response one cycle after the request
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         r_valid_q <= 1'b0;
         r_opc_q   <= PER_READ;
      end
      else
      begin
         r_valid_q <= req_ok;
         if (req_ok)
            r_opc_q <= per_i.we ? PER_WRITE : PER_READ;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (req_ok)
         r_rdata_q <= mem_q[per_i.add]; // Old word on a write
   end

   assign per_i.r_valid = r_valid_q;
   assign per_i.r_opc   = r_opc_q;
   assign per_i.r_rdata = r_rdata_q;

endmodule

//--- testbench/tb_axi2per_model.svh
`ifndef TB_AXI2PER_MODEL_SVH
`define TB_AXI2PER_MODEL_SVH

// Shadow of all banks, indexed by address bits 9:2
logic [PER_DATA_WIDTH-1:0] shadow_mem [256];

function automatic void clear_shadow();
   for (int i = 0; i < 256; i++)
      shadow_mem[i] = '0;
endfunction

// Stored word placed in the half chosen by bit 2, other half zero
function automatic logic [AXI_DATA_WIDTH-1:0] expected_rdata(
   input logic [AXI_ADDR_WIDTH-1:0] addr
);
   logic [PER_DATA_WIDTH-1:0] word;
   word = shadow_mem[addr[9:2]];
   if (addr[2])
      return {word, {PER_DATA_WIDTH{1'b0}}};
   else
      return {{PER_DATA_WIDTH{1'b0}}, word};
endfunction

// Merge the strobed bytes of the chosen half
function automatic void apply_write(
   input logic [AXI_ADDR_WIDTH-1:0] addr,
   input logic [AXI_DATA_WIDTH-1:0] data,
   input logic [AXI_STRB_WIDTH-1:0] strb
);
   logic [PER_DATA_WIDTH-1:0] half_data;
   logic [PER_BE_WIDTH-1:0]   half_strb;
   half_data = addr[2] ? data[AXI_DATA_WIDTH-1:PER_DATA_WIDTH] : data[PER_DATA_WIDTH-1:0];
   half_strb = addr[2] ? strb[AXI_STRB_WIDTH-1:PER_BE_WIDTH] : strb[PER_BE_WIDTH-1:0];
   for (int b = 0; b < PER_BE_WIDTH; b++)
      if (half_strb[b])
         shadow_mem[addr[9:2]][8*b +: 8] = half_data[8*b +: 8];
endfunction

`endif

//--- testbench/tb_axi2per.sv
`timescale 1ns/1ps

module tb_axi2per;
   import axi2per_pkg::*;

   localparam int unsigned N_RANDOM   = 200;
   localparam int unsigned N_DIRECTED = 40;  // Upper bound on directed transfers
   // A random step may offer a read and a write together
   localparam int unsigned MAX_CYCLES = (N_DIRECTED + 2 * N_RANDOM) * 20;

   typedef struct packed {
      logic                      write;
      logic [AXI_ID_WIDTH-1:0]   id;
      logic [AXI_DATA_WIDTH-1:0] data;
   } expect_t;

   logic                      clk_i;
   logic                      rst_ni;
   logic                      ar_valid_i;
   logic [AXI_ADDR_WIDTH-1:0] ar_addr_i;
   logic [AXI_ID_WIDTH-1:0]   ar_id_i;
   logic                      ar_ready_o;
   logic                      aw_valid_i;
   logic [AXI_ADDR_WIDTH-1:0] aw_addr_i;
   logic [AXI_ID_WIDTH-1:0]   aw_id_i;
   logic                      aw_ready_o;
   logic                      w_valid_i;
   logic [AXI_DATA_WIDTH-1:0] w_data_i;
   logic [AXI_STRB_WIDTH-1:0] w_strb_i;
   logic                      w_ready_o;
   logic                      r_valid_o;
   logic [AXI_DATA_WIDTH-1:0] r_data_o;
   axi_resp_e                 r_resp_o;
   logic                      r_last_o;
   logic [AXI_ID_WIDTH-1:0]   r_id_o;
   logic                      r_ready_i;
   logic                      b_valid_o;
   axi_resp_e                 b_resp_o;
   logic [AXI_ID_WIDTH-1:0]   b_id_o;
   logic                      b_ready_i;

   expect_t                   exp_q [$];  // One entry per accepted transfer
   expect_t                   exp_head;
   logic                      r_stall = 1'b0;
   logic [AXI_DATA_WIDTH-1:0] r_held_data;
   logic [AXI_ID_WIDTH-1:0]   r_held_id;
   logic                      b_stall = 1'b0;
   logic [AXI_ID_WIDTH-1:0]   b_held_id;
   int unsigned               cycle_cnt = 0;

   `include "tb_axi2per_model.svh"

   axi2per_top #(
      .N_BANKS    (4),
      .BANK_WORDS (64)
   ) axi2per_top_i (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // ******************************
   // Helpers and compare tasks
   // ******************************
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_r(input logic [AXI_DATA_WIDTH-1:0] exp_data,
                          input logic [AXI_ID_WIDTH-1:0]   exp_id,
                          input axi_resp_e                 exp_resp,
                          input logic                      exp_last);
      if (r_data_o !== exp_data)
         stop_run($sformatf("FAIL r_data_o: expected %h, got %h", exp_data, r_data_o));
      else if (r_id_o !== exp_id)
         stop_run($sformatf("FAIL r_id_o: expected %h, got %h", exp_id, r_id_o));
      else if (r_resp_o !== exp_resp)
         stop_run($sformatf("FAIL r_resp_o: expected %h, got %h", exp_resp, r_resp_o));
      else if (r_last_o !== exp_last)
         stop_run($sformatf("FAIL r_last_o: expected %h, got %h", exp_last, r_last_o));
   endtask

   task automatic check_b(input logic [AXI_ID_WIDTH-1:0] exp_id,
                          input axi_resp_e               exp_resp);
      if (b_id_o !== exp_id)
         stop_run($sformatf("FAIL b_id_o: expected %h, got %h", exp_id, b_id_o));
      else if (b_resp_o !== exp_resp)
         stop_run($sformatf("FAIL b_resp_o: expected %h, got %h", exp_resp, b_resp_o));
   endtask

   function automatic logic [AXI_ADDR_WIDTH-1:0] random_addr();
      return $urandom & 32'hFFFF_FF1C;  // 16 locations where the upper bits alias
   endfunction

   // Offers AR and/or AW+W together and returns once all are accepted
   task automatic run_transfer(input logic do_rd, input logic do_wr,
                               input logic [AXI_ADDR_WIDTH-1:0] raddr,
                               input logic [AXI_ID_WIDTH-1:0]   rid,
                               input logic [AXI_ADDR_WIDTH-1:0] waddr,
                               input logic [AXI_ID_WIDTH-1:0]   wid,
                               input logic [AXI_DATA_WIDTH-1:0] wdata,
                               input logic [AXI_STRB_WIDTH-1:0] wstrb);
      logic rd_pend;
      logic wr_pend;
      rd_pend    = do_rd;
      wr_pend    = do_wr;
      ar_valid_i = do_rd;
      ar_addr_i  = raddr;
      ar_id_i    = rid;
      aw_valid_i = do_wr;
      aw_addr_i  = waddr;
      aw_id_i    = wid;
      w_valid_i  = do_wr;
      w_data_i   = wdata;
      w_strb_i   = wstrb;
      while (rd_pend || wr_pend)
      begin
         @(negedge clk_i);
         if (ar_valid_i && ar_ready_o)
            rd_pend = 1'b0;
         if (aw_valid_i && aw_ready_o && w_ready_o)
            wr_pend = 1'b0;
         @(posedge clk_i);
         #1;
         ar_valid_i = rd_pend;
         aw_valid_i = wr_pend;
         w_valid_i  = wr_pend;
      end
   endtask

   // ******************************
   // Compare process
   // ******************************
   always @(negedge clk_i)
   begin
      if (!rst_ni)
      begin
         if (ar_ready_o || aw_ready_o || w_ready_o || r_valid_o || b_valid_o)
            stop_run("A ready or valid output was high during reset");
      end
      else
      begin
         if (r_stall)
         begin
            if (!r_valid_o)
               stop_run("r_valid_o dropped before the handshake");
            else
               check_r(r_held_data, r_held_id, OKAY, 1'b1);  // Payload held
         end
         if (b_stall)
         begin
            if (!b_valid_o)
               stop_run("b_valid_o dropped before the handshake");
            else
               check_b(b_held_id, OKAY);
         end
         if ((r_valid_o || b_valid_o) && (ar_ready_o || aw_ready_o))
            stop_run("An address was accepted while a response was pending");
         if (ar_valid_i && (aw_ready_o || w_ready_o))
            stop_run("A write was accepted while a read was offered");

         if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i))
         begin
            if (exp_q.size() == 0)
               stop_run("A response arrived without an accepted transfer");
            else
            begin
               exp_head = exp_q.pop_front();
               if (r_valid_o && exp_head.write)
                  stop_run("An R response arrived where a B response was due");
               else if (b_valid_o && !exp_head.write)
                  stop_run("A B response arrived where an R response was due");
               else if (r_valid_o)
                  check_r(exp_head.data, exp_head.id, OKAY, 1'b1);
               else
                  check_b(exp_head.id, OKAY);
            end
         end
         r_stall     = r_valid_o && !r_ready_i;
         r_held_data = r_data_o;
         r_held_id   = r_id_o;
         b_stall     = b_valid_o && !b_ready_i;
         b_held_id   = b_id_o;

         // Model follows the order of acceptance
         if (ar_valid_i && ar_ready_o)
            exp_q.push_back(expect_t'{write: 1'b0, id: ar_id_i,
                                      data: expected_rdata(ar_addr_i)});
         if (aw_valid_i && aw_ready_o && w_ready_o)
         begin
            apply_write(aw_addr_i, w_data_i, w_strb_i);
            exp_q.push_back(expect_t'{write: 1'b1, id: aw_id_i, data: '0});
         end
      end
   end

   // Random back-pressure of 0 to 6 cycles on R and B
   initial
   begin : ready_driver
      int unsigned gap;
      forever
      begin
         @(posedge clk_i);
         #1;
         if (r_valid_o || b_valid_o)
         begin
            gap = $urandom % 7;
            repeat (gap)
            begin
               @(posedge clk_i);
               #1;
            end
            r_ready_i = r_valid_o;
            b_ready_i = b_valid_o;
            @(posedge clk_i);
            #1;
            r_ready_i = 1'b0;
            b_ready_i = 1'b0;
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES)
         stop_run($sformatf("Timeout, the run did not end within %0d cycles", MAX_CYCLES));
   end

   // ******************************
   // Stimulus
   // ******************************
   initial
   begin : stimulus
      logic [AXI_ADDR_WIDTH-1:0] addr;
      int unsigned               kind;
      void'($urandom(32'h9a91));
      rst_ni     = 1'b0;
      ar_valid_i = 1'b0;
      ar_addr_i  = '0;
      ar_id_i    = '0;
      aw_valid_i = 1'b0;
      aw_addr_i  = '0;
      aw_id_i    = '0;
      w_valid_i  = 1'b0;
      w_data_i   = '0;
      w_strb_i   = '0;
      r_ready_i  = 1'b0;
      b_ready_i  = 1'b0;
      clear_shadow();
      repeat (3)
         @(posedge clk_i);
      #1;
      rst_ni = 1'b1;

      for (int b = 0; b < 4; b++)  // First word of each bank
         run_transfer(1'b1, 1'b0, 32'(b * 256), AXI_ID_WIDTH'(b), '0, '0, '0, '0);

      // Full writes to every bank and half and then a read back
      for (int b = 0; b < 4; b++)
         for (int h = 0; h < 2; h++)
         begin
            addr = 32'(b * 256 + h * 4 + 8);
            run_transfer(1'b0, 1'b1, '0, '0, addr, AXI_ID_WIDTH'(b * 2 + h),
                         {$urandom, $urandom}, '1);
         end
      for (int b = 0; b < 4; b++)
         for (int h = 0; h < 2; h++)
         begin
            addr = 32'(b * 256 + h * 4 + 8);
            run_transfer(1'b1, 1'b0, addr, AXI_ID_WIDTH'(15 - b * 2 - h), '0, '0, '0, '0);
         end

      // Partial strobes on the lower and then the upper half
      run_transfer(1'b0, 1'b1, '0, '0, 32'h210, 4'h3, {$urandom, $urandom}, 8'h5A);
      run_transfer(1'b1, 1'b0, 32'h210, 4'h4, '0, '0, '0, '0);
      run_transfer(1'b0, 1'b1, '0, '0, 32'h214, 4'h5, {$urandom, $urandom}, 8'h3C);
      run_transfer(1'b1, 1'b0, 32'h214, 4'h6, '0, '0, '0, '0);

      // Kind 0 is a read, 1 a write and 2 both offered together
      for (int n = 0; n < N_RANDOM; n++)
      begin
         kind = $urandom % 3;
         run_transfer(kind != 1, kind != 0, random_addr(), AXI_ID_WIDTH'($urandom),
                      random_addr(), AXI_ID_WIDTH'($urandom), {$urandom, $urandom},
                      AXI_STRB_WIDTH'($urandom));
      end

      while (exp_q.size() != 0)
         @(posedge clk_i);
      repeat (10)  // Room for a stray response after the last one
         @(posedge clk_i);
      #1;
      $display("Test OK");
      $finish;
   end

endmodule
